//--- Makefile
# Verilator build and run for the stream data-width upsizer

VERILATOR ?= verilator
TOP       ?= tb_dwc_upsizer
BUILD_DIR ?= build
LOG       ?= sim.log

FILELIST := build.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
dwc_pkg.sv
dwc_dispatch.sv
dwc_upsize_lane.sv
dwc_collect.sv
dwc_upsizer.sv
tb_dwc_upsizer.sv

//--- dwc_collect.sv
module dwc_collect #(
  parameter int unsigned MgrDataWidth = dwc_pkg::DefaultMgrDataWidth,
  parameter int unsigned IdWidth      = dwc_pkg::DefaultIdWidth,
  parameter int unsigned NumLanes     = 2**IdWidth
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Lane outputs, lane k in slice k
  input  logic [NumLanes-1:0]                word_valid_i,
  input  logic [NumLanes*MgrDataWidth-1:0]   word_data_i,
  input  logic [NumLanes*MgrDataWidth/8-1:0] word_strb_i,
  input  logic [NumLanes-1:0]                word_last_i,
  // Manager side
  output logic                               mgr_valid_o,
  output logic [IdWidth-1:0]                 mgr_id_o,
  output logic [MgrDataWidth-1:0]            mgr_data_o,
  output logic [MgrDataWidth/8-1:0]          mgr_strb_o,
  output logic                               mgr_last_o
);

  localparam int unsigned MgrStrbWidth = MgrDataWidth / 8;

  logic [IdWidth-1:0]      sel_id;
  logic [MgrDataWidth-1:0] sel_data;
  logic [MgrStrbWidth-1:0] sel_strb;
  logic                    sel_last;

  // Pick the valid lane, its index becomes the output ID
  always_comb begin
    sel_id   = '0;
    sel_data = '0;
    sel_strb = '0;
    sel_last = 1'b0;
    for (int unsigned k = 0; k < NumLanes; k++) begin
      if (word_valid_i[k]) begin
        sel_id   = IdWidth'(k);
        sel_data = word_data_i[k*MgrDataWidth +: MgrDataWidth];
        sel_strb = word_strb_i[k*MgrStrbWidth +: MgrStrbWidth];
        sel_last = word_last_i[k];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mgr_valid_o <= 1'b0;
    end else begin
      mgr_valid_o <= |word_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|word_valid_i) begin
      mgr_id_o   <= sel_id;
      mgr_data_o <= sel_data;
      mgr_strb_o <= sel_strb;
      mgr_last_o <= sel_last;
    end
  end

  // Lanes share one input and equal latency, so two words never meet here
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(word_valid_i))
    else $error("dwc_collect: more than one lane emitted a word");

endmodule : dwc_collect

//--- dwc_dispatch.sv
module dwc_dispatch #(
  parameter int unsigned SbrDataWidth = dwc_pkg::DefaultSbrDataWidth,
  parameter int unsigned IdWidth      = dwc_pkg::DefaultIdWidth,
  parameter int unsigned NumLanes     = 2**IdWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Subordinate side
  input  logic                    sbr_valid_i,
  input  logic [IdWidth-1:0]      sbr_id_i,
  input  logic [SbrDataWidth-1:0] sbr_data_i,
  input  logic                    sbr_last_i,
  // Lane side
  output logic [NumLanes-1:0]     lane_valid_o,
  output logic [SbrDataWidth-1:0] lane_data_o,
  output logic                    lane_last_o
);

  logic [NumLanes-1:0] lane_sel; // One-hot decode of the beat ID

  always_comb begin
    lane_sel = '0;
    if (sbr_valid_i) begin
      lane_sel[sbr_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_valid_o <= '0;
    end else begin
      lane_valid_o <= lane_sel;
    end
  end

  // Beat payload goes to all lanes and only the selected one samples it
  always_ff @(posedge clk_i) begin
    if (sbr_valid_i) begin
      lane_data_o <= sbr_data_i;
      lane_last_o <= sbr_last_i;
    end
  end

  // An ID without a lane would drop the beat silently
  assert property (@(posedge clk_i) disable iff (rst_i)
    sbr_valid_i |-> (sbr_id_i < NumLanes))
    else $error("dwc_dispatch: ID %0d has no lane", sbr_id_i);

endmodule : dwc_dispatch

//--- dwc_pkg.sv
package dwc_pkg;

  // Default port widths, overridden from the top level
  localparam int unsigned DefaultSbrDataWidth = 8;  // Narrow beat width in bits
  localparam int unsigned DefaultMgrDataWidth = 32; // Wide word width in bits
  localparam int unsigned DefaultIdWidth      = 2;  // Four packing lanes

  // Number of narrow slots in one wide word
  function automatic int unsigned ratio(
    input int unsigned mgr_width,
    input int unsigned sbr_width
  );
    return mgr_width / sbr_width;
  endfunction

  // Width of a counter that indexes num_slots slots, never below one bit
  function automatic int unsigned slot_width(input int unsigned num_slots);
    int unsigned width;
    width = 1;
    if (num_slots > 1) begin
      width = $clog2(num_slots);
    end
    return width;
  endfunction

endpackage : dwc_pkg

//--- dwc_upsize_lane.sv
module dwc_upsize_lane #(
  parameter int unsigned SbrDataWidth = dwc_pkg::DefaultSbrDataWidth,
  parameter int unsigned MgrDataWidth = dwc_pkg::DefaultMgrDataWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Narrow beats from the dispatcher
  input  logic                      beat_valid_i,
  input  logic [SbrDataWidth-1:0]   beat_data_i,
  input  logic                      beat_last_i,
  // Packed wide words to the collector
  output logic                      word_valid_o,
  output logic [MgrDataWidth-1:0]   word_data_o,
  output logic [MgrDataWidth/8-1:0] word_strb_o,
  output logic                      word_last_o
);

  import dwc_pkg::*;

  localparam int unsigned Ratio        = ratio(MgrDataWidth, SbrDataWidth);
  localparam int unsigned SlotWidth    = slot_width(Ratio);
  localparam int unsigned SbrStrbWidth = SbrDataWidth / 8;
  localparam int unsigned MgrStrbWidth = MgrDataWidth / 8;

  logic [SlotWidth-1:0]    slot_q;    // Next free slot in the partial word
  logic [MgrDataWidth-1:0] word_q;
  logic [MgrStrbWidth-1:0] strb_q;
  logic [MgrDataWidth-1:0] word_next; // Partial word with the current beat placed
  logic [MgrStrbWidth-1:0] strb_next;
  logic                    word_done;

  // Place the beat at its slot and mark its bytes
  always_comb begin
    word_next = word_q;
    strb_next = strb_q;
    word_next[slot_q*SbrDataWidth +: SbrDataWidth] = beat_data_i;
    strb_next[slot_q*SbrStrbWidth +: SbrStrbWidth] = '1;
  end

  // Word goes out when the last slot is filled or the burst ends
  assign word_done = beat_valid_i && (beat_last_i || (slot_q == SlotWidth'(Ratio - 1)));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_q       <= '0;
      word_q       <= '0;
      strb_q       <= '0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= word_done;
      if (word_done) begin
        slot_q <= '0; // Restart with an empty word
        word_q <= '0;
        strb_q <= '0;
      end else if (beat_valid_i) begin
        slot_q <= slot_q + 1'b1;
        word_q <= word_next;
        strb_q <= strb_next;
      end
    end
  end

  // Output word register
  always_ff @(posedge clk_i) begin
    if (word_done) begin
      word_data_o <= word_next;
      word_strb_o <= strb_next;
      word_last_o <= beat_last_i;
    end
  end

  // Width relations the slot arithmetic depends on
  initial begin
    assert (MgrDataWidth % SbrDataWidth == 0)
      else $fatal(1, "dwc_upsize_lane: %0d is not a multiple of %0d",
                  MgrDataWidth, SbrDataWidth);
    assert (SbrDataWidth % 8 == 0)
      else $fatal(1, "dwc_upsize_lane: beat width %0d is not whole bytes", SbrDataWidth);
  end

endmodule : dwc_upsize_lane

//--- dwc_upsizer.sv
module dwc_upsizer #(
  parameter int unsigned SbrDataWidth = dwc_pkg::DefaultSbrDataWidth,
  parameter int unsigned MgrDataWidth = dwc_pkg::DefaultMgrDataWidth,
  parameter int unsigned IdWidth      = dwc_pkg::DefaultIdWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Subordinate port, narrow beats
  input  logic                      sbr_valid_i,
  input  logic [IdWidth-1:0]        sbr_id_i,
  input  logic [SbrDataWidth-1:0]   sbr_data_i,
  input  logic                      sbr_last_i,
  // Manager port, packed words
  output logic                      mgr_valid_o,
  output logic [IdWidth-1:0]        mgr_id_o,
  output logic [MgrDataWidth-1:0]   mgr_data_o,
  output logic [MgrDataWidth/8-1:0] mgr_strb_o,
  output logic                      mgr_last_o
);

  localparam int unsigned NumLanes     = 2**IdWidth; // One lane per ID
  localparam int unsigned MgrStrbWidth = MgrDataWidth / 8;

  logic [NumLanes-1:0]              lane_valid;
  logic [SbrDataWidth-1:0]          lane_data;
  logic                             lane_last;
  logic [NumLanes-1:0]              word_valid;
  logic [NumLanes*MgrDataWidth-1:0] word_data;
  logic [NumLanes*MgrStrbWidth-1:0] word_strb;
  logic [NumLanes-1:0]              word_last;

  dwc_dispatch #(
    .SbrDataWidth (SbrDataWidth),
    .IdWidth      (IdWidth     ),
    .NumLanes     (NumLanes    )
  ) i_dispatch (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .sbr_valid_i  (sbr_valid_i),
    .sbr_id_i     (sbr_id_i   ),
    .sbr_data_i   (sbr_data_i ),
    .sbr_last_i   (sbr_last_i ),
    .lane_valid_o (lane_valid ),
    .lane_data_o  (lane_data  ),
    .lane_last_o  (lane_last  )
  );

  for (genvar k = 0; k < NumLanes; k++) begin : gen_lane
    dwc_upsize_lane #(
      .SbrDataWidth (SbrDataWidth),
      .MgrDataWidth (MgrDataWidth)
    ) i_lane (
      .clk_i        (clk_i                                      ),
      .rst_i        (rst_i                                      ),
      .beat_valid_i (lane_valid[k]                              ),
      .beat_data_i  (lane_data                                  ),
      .beat_last_i  (lane_last                                  ),
      .word_valid_o (word_valid[k]                              ),
      .word_data_o  (word_data[k*MgrDataWidth +: MgrDataWidth]  ),
      .word_strb_o  (word_strb[k*MgrStrbWidth +: MgrStrbWidth]  ),
      .word_last_o  (word_last[k]                               )
    );
  end : gen_lane

  dwc_collect #(
    .MgrDataWidth (MgrDataWidth),
    .IdWidth      (IdWidth     ),
    .NumLanes     (NumLanes    )
  ) i_collect (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .word_valid_i (word_valid ),
    .word_data_i  (word_data  ),
    .word_strb_i  (word_strb  ),
    .word_last_i  (word_last  ),
    .mgr_valid_o  (mgr_valid_o),
    .mgr_id_o     (mgr_id_o   ),
    .mgr_data_o   (mgr_data_o ),
    .mgr_strb_o   (mgr_strb_o ),
    .mgr_last_o   (mgr_last_o )
  );

endmodule : dwc_upsizer

//--- tb_dwc_upsizer.sv
module tb_dwc_upsizer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SbrW        = dwc_pkg::DefaultSbrDataWidth;
  localparam int MgrW        = dwc_pkg::DefaultMgrDataWidth;
  localparam int IdW         = dwc_pkg::DefaultIdWidth;
  localparam int Slots       = MgrW / SbrW; // Narrow beats per wide word
  localparam int SbrBytes    = SbrW / 8;
  localparam int NumIds      = 2**IdW;
  localparam int NumBursts   = 11;
  localparam int ResetCycles = 3;
  localparam int GapCycles   = 2;  // Idle cycles after each burst group
  localparam int DrainCycles = 4;
  localparam int Margin      = 20;

  // Burst table where consecutive interleaved entries share cycles
  string names [NumBursts] = '{"full_id0", "partial_1", "partial_2", "partial_3",
                               "multi_10", "ilv_a", "ilv_b", "full_id3",
                               "b2b_a", "b2b_b", "partial_after"};
  int    ids   [NumBursts] = '{0, 1, 2, 3, 1, 2, 3, 3, 0, 1, 2};
  int    beats [NumBursts] = '{4, 1, 2, 3, 10, 5, 6, 4, 4, 4, 3};
  bit    ilv   [NumBursts] = '{0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 0};

  logic              clk_i;
  logic              rst_i;
  logic              sbr_valid_i;
  logic [IdW-1:0]    sbr_id_i;
  logic [SbrW-1:0]   sbr_data_i;
  logic              sbr_last_i;
  logic              mgr_valid_o;
  logic [IdW-1:0]    mgr_id_o;
  logic [MgrW-1:0]   mgr_data_o;
  logic [MgrW/8-1:0] mgr_strb_o;
  logic              mgr_last_o;

  integer seed = 32'h0e495218;
  int     cycle;
  int     limit;
  int     mismatch_count;
  int     other_count;

  // Reference packing state with one partial word per ID
  logic [MgrW-1:0]   part_word [NumIds];
  logic [MgrW/8-1:0] part_strb [NumIds];
  int                part_slot [NumIds];

  // Expected words in completion order
  string             q_name  [$];
  int                q_id    [$];
  logic [MgrW-1:0]   q_data  [$];
  logic [MgrW/8-1:0] q_strb  [$];
  bit                q_last  [$];
  int                q_cycle [$];

  dwc_upsizer DUT (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .sbr_valid_i (sbr_valid_i),
    .sbr_id_i    (sbr_id_i   ),
    .sbr_data_i  (sbr_data_i ),
    .sbr_last_i  (sbr_last_i ),
    .mgr_valid_o (mgr_valid_o),
    .mgr_id_o    (mgr_id_o   ),
    .mgr_data_o  (mgr_data_o ),
    .mgr_strb_o  (mgr_strb_o ),
    .mgr_last_o  (mgr_last_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Reset, every beat, every gap, the drain and a margin
  function automatic int cycle_budget();
    int total;
    total = ResetCycles + DrainCycles + Margin;
    for (int k = 0; k < NumBursts; k++) begin
      total += beats[k];
      if (!ilv[k] || k == 0 || !ilv[k-1]) total += GapCycles; // New group starts here
    end
    return total;
  endfunction

  // Packs lowest slot first and queues a word when full or when the burst ends
  task automatic model_beat(input int id, input logic [SbrW-1:0] data, input bit last,
                            input string name);
    int slot;
    slot = part_slot[id];
    part_word[id][slot*SbrW +: SbrW] = data;
    part_strb[id][slot*SbrBytes +: SbrBytes] = '1;
    part_slot[id] = slot + 1;
    if (last || part_slot[id] == Slots) begin
      q_name.push_back(name);
      q_id.push_back(id);
      q_data.push_back(part_word[id]);
      q_strb.push_back(part_strb[id]);
      q_last.push_back(last);
      q_cycle.push_back(cycle);
      part_word[id] = '0; // Unused slots of the next word stay zero
      part_strb[id] = '0;
      part_slot[id] = 0;
    end
  endtask

  task automatic drive_beat(input int k, input bit last);
    logic [31:0] rnd;
    @(posedge clk_i);
    #1;
    rnd = $random(seed);
    sbr_valid_i = 1'b1;
    sbr_id_i    = IdW'(ids[k]);
    sbr_data_i  = rnd[SbrW-1:0];
    sbr_last_i  = last;
    model_beat(ids[k], rnd[SbrW-1:0], last, names[k]);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      sbr_valid_i = 1'b0;
      sbr_last_i  = 1'b0;
    end
  endtask

  task automatic check_word();
    string           name;
    logic [MgrW-1:0] exp_data;
    if (q_data.size() == 0) begin
      other_count++;
      $display("mgr_valid_o went high at cycle %0d with no word expected", cycle);
    end else begin
      name     = q_name.pop_front();
      exp_data = q_data.pop_front();
      if (mgr_id_o !== IdW'(q_id[0])) begin
        mismatch_count++;
        $display("Mismatch %s id: expected %0d, actual %0d", name, q_id[0], mgr_id_o);
      end
      if (mgr_data_o !== exp_data) begin
        mismatch_count++;
        $display("Mismatch %s data: expected %h, actual %h", name, exp_data, mgr_data_o);
      end
      if (mgr_strb_o !== q_strb[0]) begin
        mismatch_count++;
        $display("Mismatch %s strb: expected %b, actual %b", name, q_strb[0], mgr_strb_o);
      end
      if (mgr_last_o !== q_last[0]) begin
        mismatch_count++;
        $display("Mismatch %s last: expected %b, actual %b", name, q_last[0], mgr_last_o);
      end
      if (cycle != q_cycle[0] + 3) begin
        mismatch_count++;
        $display("Mismatch %s cycle: expected %0d, actual %0d", name, q_cycle[0] + 3, cycle);
      end
      void'(q_id.pop_front());
      void'(q_strb.pop_front());
      void'(q_last.pop_front());
      void'(q_cycle.pop_front());
    end
  endtask

  // Outputs settle after the rising edge and are sampled on the falling one
  always @(negedge clk_i) begin
    if (rst_i && cycle > 0 && mgr_valid_o !== 1'b0) begin
      other_count++;
      $display("mgr_valid_o is not low during reset at cycle %0d", cycle);
    end else if (!rst_i && mgr_valid_o === 1'b1) begin
      check_word();
    end else if (!rst_i && mgr_valid_o !== 1'b0) begin
      other_count++;
      $display("mgr_valid_o is unknown at cycle %0d", cycle);
    end
  end

  always @(posedge clk_i) begin
    cycle++;
    if (cycle >= limit) begin
      $display("Timeout after %0d cycles, %0d expected words never appeared",
               cycle, q_data.size());
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int i;
    int grp_end;
    bit pending;
    int sent [NumBursts];
    limit          = cycle_budget();
    cycle          = 0;
    mismatch_count = 0;
    other_count    = 0;
    rst_i          = 1'b1;
    sbr_valid_i    = 1'b0;
    sbr_id_i       = '0;
    sbr_data_i     = '0;
    sbr_last_i     = 1'b0;
    for (int id = 0; id < NumIds; id++) begin
      part_word[id] = '0;
      part_strb[id] = '0;
      part_slot[id] = 0;
    end
    for (int k = 0; k < NumBursts; k++) sent[k] = 0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    i = 0;
    while (i < NumBursts) begin
      grp_end = i;
      if (ilv[i]) begin
        while (grp_end + 1 < NumBursts && ilv[grp_end+1]) grp_end++;
      end
      pending = 1'b1;
      while (pending) begin
        pending = 1'b0;
        for (int k = i; k <= grp_end; k++) begin // One beat per burst in turn
          if (sent[k] < beats[k]) begin
            drive_beat(k, sent[k] == beats[k] - 1);
            sent[k]++;
            pending = 1'b1;
          end
        end
      end
      drive_idle(GapCycles);
      i = grp_end + 1;
    end
    while (q_data.size() != 0) @(posedge clk_i);
    drive_idle(DrainCycles); // Catch stray words after the last expected one
    if (q_data.size() != 0) begin
      other_count++;
      $display("%0d expected words were never produced", q_data.size());
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_dwc_upsizer
